//--- common/soc_pkg.sv
`default_nettype none

package soc_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int MASK_W = DATA_W / 8; // one bit per byte lane

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [MASK_W-1:0] mask_t;

  localparam int BANK_COUNT   = 4;
  localparam int BANK_WORDS   = 256;
  localparam int BANK_IDX_LSB = 10; // bank number starts above the word index

  localparam addr_t RAM_BASE = 32'h0000_0000;
  localparam addr_t RAM_SPAN = 32'h0000_1000; // 4 KiB

  localparam addr_t GPIO_BASE  = 32'hC000_0000;
  localparam addr_t LED_OFFSET = 32'h0000_0000;
  localparam addr_t KEY_OFFSET = 32'h0000_0004;

  localparam int LED_W = 8;
  localparam int KEY_W = 2;

  localparam int TARGET_COUNT = BANK_COUNT + 1; // banks first, gpio last

  typedef logic [$clog2(TARGET_COUNT)-1:0] target_t;

endpackage

`default_nettype wire

//--- common/soc_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface soc_bus_if;
  import soc_pkg::*;

  logic  req;
  logic  write;
  addr_t addr;
  data_t wdata;
  mask_t rd_mask;
  mask_t wr_mask;
  logic  ack;   // one-cycle pulse
  data_t rdata; // valid with ack

  modport initiator (
    output req, write, addr, wdata, rd_mask, wr_mask,
    input  ack, rdata
  );

  modport target (
    input  req, write, addr, wdata, rd_mask, wr_mask,
    output ack, rdata
  );

  modport monitor (
    input req, write, addr, wdata, rd_mask, wr_mask, ack, rdata
  );

endinterface

`default_nettype wire

//--- fabric/mem_map_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module mem_map_decoder (
  input  wire logic             clk,
  input  wire logic             i_rst_n,

  input  wire logic             i_req,
  input  wire logic             i_write,
  input  wire soc_pkg::addr_t   i_addr,
  input  wire soc_pkg::data_t   i_wdata,
  input  wire soc_pkg::mask_t   i_rd_mask,
  input  wire soc_pkg::mask_t   i_wr_mask,
  input  wire logic             i_resp_done, // master ack has gone out

  soc_bus_if.initiator          bus_if [0:soc_pkg::TARGET_COUNT-1],

  output logic                  o_miss
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_DRAIN
  } state_t;

  state_t                  state;
  addr_t                   word_addr;
  addr_t                   ram_off;
  addr_t                   gpio_off;
  logic                    ram_hit;
  logic                    gpio_hit;
  logic                    hit;
  logic                    accept;
  target_t                 dec_sel;
  logic [TARGET_COUNT-1:0] ack_vec;

  target_t                 sel_r;
  logic                    write_r;
  addr_t                   addr_r;
  data_t                   wdata_r;
  mask_t                   rd_mask_r;
  mask_t                   wr_mask_r;

  assign word_addr = {i_addr[ADDR_W-1:$clog2(MASK_W)], {$clog2(MASK_W){1'b0}}};
  assign ram_off   = word_addr - RAM_BASE;
  assign gpio_off  = word_addr - GPIO_BASE;
  assign ram_hit   = ram_off < RAM_SPAN;      // wraps for addresses below base
  assign gpio_hit  = gpio_off <= KEY_OFFSET;
  assign hit       = ram_hit || gpio_hit;
  assign accept    = (state == ST_IDLE) && i_req;

  always_comb
  begin
    if (gpio_hit)
      dec_sel = target_t'(BANK_COUNT);
    else
      dec_sel = target_t'(ram_off[BANK_IDX_LSB +: $clog2(BANK_COUNT)]);
  end

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      state  <= ST_IDLE;
      o_miss <= 1'b0;
    end
    else
    begin
      o_miss <= accept && !hit;
      case (state)
        ST_IDLE:
          if (i_req)
            state <= hit ? ST_WAIT : ST_DRAIN; // a miss skips the target
        ST_WAIT:
          if (ack_vec[sel_r])
            state <= ST_DRAIN;
        ST_DRAIN:
          if (i_resp_done)
            state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // request fields held stable for the whole transfer
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      sel_r     <= dec_sel;
      write_r   <= i_write;
      addr_r    <= word_addr;
      wdata_r   <= i_wdata;
      rd_mask_r <= i_rd_mask;
      wr_mask_r <= i_wr_mask;
    end
  end

  for (genvar g = 0; g < TARGET_COUNT; g++)
  begin : g_target
    assign bus_if[g].req     = (state == ST_WAIT) && (sel_r == target_t'(g));
    assign bus_if[g].write   = write_r;
    assign bus_if[g].addr    = addr_r;
    assign bus_if[g].wdata   = wdata_r;
    assign bus_if[g].rd_mask = rd_mask_r;
    assign bus_if[g].wr_mask = wr_mask_r;
    assign ack_vec[g]        = bus_if[g].ack;
  end

endmodule

`default_nettype wire

//--- fabric/response_collector.sv
`timescale 1ns/100ps
`default_nettype none

module response_collector (
  input  wire logic        clk,
  input  wire logic        i_rst_n,
  input  wire logic        i_miss,

  soc_bus_if.monitor       bus_if [0:soc_pkg::TARGET_COUNT-1],

  output logic             o_ack,
  output soc_pkg::data_t   o_rdata
);
  import soc_pkg::*;

  logic [TARGET_COUNT-1:0] ack_vec;
  data_t                   rdata_vec [TARGET_COUNT];
  mask_t                   mask_vec  [TARGET_COUNT];
  data_t                   rdata_sel;
  mask_t                   mask_sel;
  data_t                   rdata_masked;

  for (genvar g = 0; g < TARGET_COUNT; g++)
  begin : g_target
    assign ack_vec[g]   = bus_if[g].ack;
    assign rdata_vec[g] = bus_if[g].ack ? bus_if[g].rdata : '0;
    assign mask_vec[g]  = bus_if[g].ack ? bus_if[g].rd_mask : '0;
  end

  // only one target acks at a time, so an OR picks it
  always_comb
  begin
    rdata_sel = '0;
    mask_sel  = '0;
    for (int i = 0; i < TARGET_COUNT; i++)
    begin
      rdata_sel = rdata_sel | rdata_vec[i];
      mask_sel  = mask_sel | mask_vec[i];
    end
    for (int b = 0; b < MASK_W; b++)
      rdata_masked[8*b +: 8] = mask_sel[b] ? rdata_sel[8*b +: 8] : 8'h00;
  end

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      o_ack <= 1'b0;
    else
      o_ack <= (|ack_vec) || i_miss;
  end

  always_ff @(posedge clk)
  begin
    o_rdata <= rdata_masked; // zero on a miss
  end

endmodule

`default_nettype wire

//--- logic/ram_bank.sv
`timescale 1ns/100ps
`default_nettype none

module ram_bank (
  input  wire logic  clk,
  input  wire logic  i_rst_n,

  soc_bus_if.target  bus
);
  import soc_pkg::*;

  data_t                          mem [BANK_WORDS];
  logic [$clog2(BANK_WORDS)-1:0]  word_idx;
  logic                           access;

  assign word_idx = bus.addr[$clog2(MASK_W) +: $clog2(BANK_WORDS)];
  assign access   = bus.req && !bus.ack; // one access per request

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      bus.ack <= 1'b0;
    else
      bus.ack <= access;
  end

  always_ff @(posedge clk)
  begin
    if (access)
    begin
      if (bus.write)
      begin
        for (int b = 0; b < MASK_W; b++)
        begin
          if (bus.wr_mask[b])
            mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
      bus.rdata <= mem[word_idx]; // old word on a write
    end
  end

endmodule

`default_nettype wire

//--- logic/gpio_regs.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_regs (
  input  wire logic [soc_pkg::KEY_W-1:0]  i_key,
  input  wire logic                       clk,
  input  wire logic                       i_rst_n,

  output logic [soc_pkg::LED_W-1:0]       o_led,

  soc_bus_if.target                       bus
);
  import soc_pkg::*;

  addr_t            reg_off;
  logic             is_led;
  logic             is_key;
  logic             access;
  logic [KEY_W-1:0] key_meta;
  logic [KEY_W-1:0] key_sync;

  assign reg_off = bus.addr - GPIO_BASE;
  assign is_led  = reg_off[ADDR_W-1:2] == LED_OFFSET[ADDR_W-1:2];
  assign is_key  = reg_off[ADDR_W-1:2] == KEY_OFFSET[ADDR_W-1:2];
  assign access  = bus.req && !bus.ack;

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
      o_led    <= '0;
      bus.ack  <= 1'b0;
    end
    else
    begin
      key_meta <= i_key; // async board input
      key_sync <= key_meta;
      bus.ack  <= access;
      if (access && bus.write && is_led && bus.wr_mask[0])
        o_led <= bus.wdata[LED_W-1:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (access)
    begin
      if (is_led)
        bus.rdata <= data_t'(o_led);
      else if (is_key)
        bus.rdata <= data_t'(key_sync);
      else
        bus.rdata <= '0;
    end
  end

endmodule

`default_nettype wire

//--- logic/soc_fabric.sv
`timescale 1ns/100ps
`default_nettype none

module soc_fabric (
  input  wire logic                       clk,
  input  wire logic                       i_rst_n,

  input  wire logic                       i_bus_req,
  input  wire logic                       i_bus_write,
  input  wire soc_pkg::addr_t             i_bus_addr,
  input  wire soc_pkg::data_t             i_bus_data,
  input  wire soc_pkg::mask_t             i_bus_rd_mask,
  input  wire soc_pkg::mask_t             i_bus_wr_mask,
  output soc_pkg::data_t                  o_bus_data,
  output logic                            o_bus_ack,

  input  wire logic [soc_pkg::KEY_W-1:0]  i_key,
  output logic [soc_pkg::LED_W-1:0]       o_led
);
  import soc_pkg::*;

  logic miss;

  soc_bus_if bus_if [0:TARGET_COUNT-1] ();

  mem_map_decoder u_decoder (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_req       (i_bus_req),
    .i_write     (i_bus_write),
    .i_addr      (i_bus_addr),
    .i_wdata     (i_bus_data),
    .i_rd_mask   (i_bus_rd_mask),
    .i_wr_mask   (i_bus_wr_mask),
    .i_resp_done (o_bus_ack),
    .bus_if      (bus_if),
    .o_miss      (miss)
  );

  for (genvar g = 0; g < BANK_COUNT; g++)
  begin : g_bank
    ram_bank u_bank (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .bus     (bus_if[g])
    );
  end

  gpio_regs u_gpio (
    .i_key   (i_key),
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .o_led   (o_led),
    .bus     (bus_if[BANK_COUNT]) // gpio sits after the banks
  );

  response_collector u_collector (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_miss  (miss),
    .bus_if  (bus_if),
    .o_ack   (o_bus_ack),
    .o_rdata (o_bus_data)
  );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial
  begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk; // 10 ns period
  end

  initial
  begin
    o_rst_n = 1'b0;
    repeat (3) @(posedge o_clk);
    #1 o_rst_n = 1'b1; // released away from the edge
  end

endmodule

`default_nettype wire

//--- sim/soc_checker.sv
`timescale 1ns/100ps
`default_nettype none

module soc_checker (
  input  wire logic                       i_clk,
  input  wire logic                       i_rst_n,
  input  wire logic                       i_bus_req,
  input  wire logic                       i_bus_write,
  input  wire soc_pkg::addr_t             i_bus_addr,
  input  wire soc_pkg::data_t             i_bus_data,
  input  wire soc_pkg::mask_t             i_bus_rd_mask,
  input  wire soc_pkg::mask_t             i_bus_wr_mask,
  input  wire logic                       i_bus_ack,
  input  wire soc_pkg::data_t             i_bus_rdata,
  input  wire logic [soc_pkg::KEY_W-1:0]  i_key,
  input  wire logic [soc_pkg::LED_W-1:0]  i_led,
  output int                              o_checks,
  output int                              o_errors
);
  import soc_pkg::*;

  localparam int RAM_WORDS = BANK_COUNT * BANK_WORDS;

  data_t            ram_data  [RAM_WORDS];
  mask_t            ram_known [RAM_WORDS]; // bytes written so far
  logic [LED_W-1:0] led_model;
  logic [KEY_W-1:0] key_q1;
  logic [KEY_W-1:0] key_q2;
  logic             busy;
  int               age;
  int               exp_lat;
  logic             exp_read;
  data_t            exp_data;
  data_t            care;

  function automatic data_t byte_mask(input mask_t m);
    data_t r;
    for (int b = 0; b < MASK_W; b++)
      r[8*b +: 8] = {8{m[b]}};
    return r;
  endfunction

  task automatic report_mismatch(input string name, input data_t expected, input data_t actual);
    o_errors++;
    $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
  endtask

  // update the model and work out what the response must be
  task automatic sample_request();
    addr_t waddr;
    int    idx;
    waddr    = {i_bus_addr[ADDR_W-1:2], 2'b00};
    exp_lat  = 3;
    exp_read = !i_bus_write;
    exp_data = '0;
    care     = '1;
    if (waddr - RAM_BASE < RAM_SPAN)
    begin
      idx = int'((waddr - RAM_BASE) >> 2);
      if (i_bus_write)
      begin
        for (int b = 0; b < MASK_W; b++)
        begin
          if (i_bus_wr_mask[b])
          begin
            ram_data[idx][8*b +: 8] = i_bus_data[8*b +: 8];
            ram_known[idx][b]       = 1'b1;
          end
        end
      end
      else
      begin
        exp_data = ram_data[idx];
        care     = ~(byte_mask(i_bus_rd_mask) & ~byte_mask(ram_known[idx])); // skip unknown bytes
      end
    end
    else if (waddr == GPIO_BASE + LED_OFFSET)
    begin
      if (i_bus_write && i_bus_wr_mask[0])
        led_model = i_bus_data[LED_W-1:0];
      exp_data = data_t'(led_model);
    end
    else if (waddr == GPIO_BASE + KEY_OFFSET)
      exp_data = data_t'(key_q2);
    else
      exp_lat = 2; // unmapped, answered with zero
    exp_data = exp_data & byte_mask(i_bus_rd_mask);
  endtask

  always @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      busy      = 1'b0;
      age       = 0;
      led_model = '0;
      key_q1    = '0;
      key_q2    = '0;
      o_checks  = 0;
      o_errors  = 0;
      for (int i = 0; i < RAM_WORDS; i++)
        ram_known[i] = '0;
    end
    else
    begin
      if (busy)
      begin
        age++;
        if (i_bus_ack)
        begin
          o_checks++;
          if (age != exp_lat)
            report_mismatch("o_bus_ack latency", exp_lat, age);
          if (exp_read)
          begin
            o_checks++;
            if ((i_bus_rdata & care) !== (exp_data & care))
              report_mismatch("o_bus_data", exp_data & care, i_bus_rdata & care);
          end
          o_checks++;
          if (i_led !== led_model)
            report_mismatch("o_led", data_t'(led_model), data_t'(i_led));
          busy = 1'b0;
        end
        else if (age == exp_lat)
        begin
          o_errors++;
          $display("ERROR at %0t: no acknowledge %0d cycles after the request", $time, exp_lat);
        end
      end
      else
      begin
        if (i_bus_ack)
        begin
          o_errors++;
          $display("ERROR at %0t: acknowledge with no request outstanding", $time);
        end
        if (i_bus_req)
        begin
          sample_request();
          busy = 1'b1;
          age  = 0;
        end
      end
      key_q2 = key_q1; // two-flop sync model
      key_q1 = i_key;
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_soc_fabric.sv
`timescale 1ns/100ps
`default_nettype none

module tb_soc_fabric;
  import soc_pkg::*;

  localparam int WRITE_COUNT = 200;
  localparam int MASK_COUNT  = 150;
  localparam int LED_COUNT   = 20;
  localparam int KEY_ROUNDS  = 4;
  localparam int KEY_HOLD    = 6;
  localparam int MISS_COUNT  = 30;
  localparam int RECHECK     = 11;
  localparam int MIX_COUNT   = 100;
  localparam int TXN_COUNT   = 2 * WRITE_COUNT + MASK_COUNT + LED_COUNT + KEY_ROUNDS
                               + MISS_COUNT + RECHECK + MIX_COUNT;
  localparam int TIMEOUT     = TXN_COUNT * 4 + KEY_ROUNDS * KEY_HOLD + MIX_COUNT + 100;

  logic             clk;
  logic             rst_n;
  logic             bus_req;
  logic             bus_write;
  addr_t            bus_addr;
  data_t            bus_data;
  mask_t            bus_rd_mask;
  mask_t            bus_wr_mask;
  logic             bus_ack;
  data_t            bus_rdata;
  logic [KEY_W-1:0] key;
  logic [LED_W-1:0] led;
  int               checks;
  int               errors;
  int               chk_base;
  int               err_base;
  int               cycles = 0;
  addr_t            pool [$]; // addresses written in the first test

  tb_clock_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  soc_fabric UUT (
    .clk           (clk),
    .i_rst_n       (rst_n),
    .i_bus_req     (bus_req),
    .i_bus_write   (bus_write),
    .i_bus_addr    (bus_addr),
    .i_bus_data    (bus_data),
    .i_bus_rd_mask (bus_rd_mask),
    .i_bus_wr_mask (bus_wr_mask),
    .o_bus_data    (bus_rdata),
    .o_bus_ack     (bus_ack),
    .i_key         (key),
    .o_led         (led)
  );

  soc_checker u_checker (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_bus_req     (bus_req),
    .i_bus_write   (bus_write),
    .i_bus_addr    (bus_addr),
    .i_bus_data    (bus_data),
    .i_bus_rd_mask (bus_rd_mask),
    .i_bus_wr_mask (bus_wr_mask),
    .i_bus_ack     (bus_ack),
    .i_bus_rdata   (bus_rdata),
    .i_key         (key),
    .i_led         (led),
    .o_checks      (checks),
    .o_errors      (errors)
  );

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > TIMEOUT)
    begin
      $display("run stopped after %0d cycles with the tests unfinished", TIMEOUT);
      $display("Checks failed");
      $finish;
    end
  end

  // called 1 ns after an edge, returns 1 ns after the ack edge
  task automatic run_txn(input logic is_write, input addr_t addr, input data_t data,
                         input mask_t rd_mask, input mask_t wr_mask);
    bus_req     = 1'b1;
    bus_write   = is_write;
    bus_addr    = addr;
    bus_data    = data;
    bus_rd_mask = rd_mask;
    bus_wr_mask = wr_mask;
    @(posedge clk);
    while (bus_ack !== 1'b1)
      @(posedge clk);
    #1;
  endtask

  task automatic idle_for(input int n);
    bus_req = 1'b0;
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name);
    $display("%-10s %0d checks, %0d errors", name, checks - chk_base, errors - err_base);
    chk_base = checks;
    err_base = errors;
  endtask

  function automatic addr_t ram_addr();
    return RAM_BASE + addr_t'($urandom_range(BANK_COUNT * BANK_WORDS - 1, 0)) * 4
           + addr_t'($urandom_range(3, 0)); // low bits are ignored
  endfunction

  function automatic addr_t unmapped_addr();
    case ($urandom_range(2, 0))
      0:       return pool[$urandom_range(RECHECK - 2, 0)]
                      + RAM_SPAN * addr_t'($urandom_range(32'hffff, 1)); // aliases a rechecked word
      1:       return GPIO_BASE + 8 + addr_t'($urandom_range(1023, 0)) * 4;
      default: return $urandom | 32'hD000_0000;
    endcase
  endfunction

  initial
  begin
    addr_t a;
    void'($urandom(32'he7ce));
    bus_req     = 1'b0;
    bus_write   = 1'b0;
    bus_addr    = '0;
    bus_data    = '0;
    bus_rd_mask = '0;
    bus_wr_mask = '0;
    key         = '0;
    chk_base    = 0;
    err_base    = 0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;

    for (int i = 0; i < WRITE_COUNT; i++)
    begin
      a = ram_addr();
      pool.push_back(a);
      run_txn(1'b1, a, $urandom, 4'hf, 4'hf);
    end
    foreach (pool[i])
      run_txn(1'b0, pool[i], '0, 4'hf, 4'h0);
    report_test("ram_rw");

    for (int i = 0; i < MASK_COUNT; i++)
      run_txn(1'($urandom_range(1, 0)), pool[$urandom_range(WRITE_COUNT - 1, 0)],
              $urandom, mask_t'($urandom), mask_t'($urandom));
    report_test("byte_mask");

    for (int i = 0; i < LED_COUNT; i++)
      run_txn(1'($urandom_range(1, 0)), GPIO_BASE + LED_OFFSET, $urandom,
              mask_t'($urandom), mask_t'($urandom));
    report_test("led");

    for (int i = 0; i < KEY_ROUNDS; i++)
    begin
      key = key + 1'b1;
      idle_for(KEY_HOLD); // let the synchronizer settle
      run_txn(1'b0, GPIO_BASE + KEY_OFFSET, '0, 4'hf, 4'h0);
    end
    report_test("keys");

    for (int i = 0; i < MISS_COUNT; i++)
      run_txn(1'($urandom_range(1, 0)), unmapped_addr(), $urandom,
              mask_t'($urandom), mask_t'($urandom));
    for (int i = 0; i < RECHECK - 1; i++)
      run_txn(1'b0, pool[i], '0, 4'hf, 4'h0);
    run_txn(1'b0, GPIO_BASE + LED_OFFSET, '0, 4'hf, 4'h0);
    report_test("unmapped");

    for (int i = 0; i < MIX_COUNT; i++)
    begin
      case ($urandom_range(3, 0))
        0:       a = ram_addr();
        1:       a = GPIO_BASE + LED_OFFSET;
        2:       a = GPIO_BASE + KEY_OFFSET;
        default: a = unmapped_addr();
      endcase
      run_txn(1'($urandom_range(1, 0)), a, $urandom, mask_t'($urandom), mask_t'($urandom));
      if ($urandom_range(1, 0) == 1)
        idle_for(1);
    end
    report_test("latency");

    $display("total %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
common/soc_pkg.sv
common/soc_bus_if.sv
fabric/mem_map_decoder.sv
fabric/response_collector.sv
logic/ram_bank.sv
logic/gpio_regs.sv
logic/soc_fabric.sv
sim/tb_clock_gen.sv
sim/soc_checker.sv
sim/tb_soc_fabric.sv
